//--- hw/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

	////////////////////////////////
	// Processor bus widths
	////////////////////////////////

	localparam int ADDR_W = 18;
	localparam int DATA_W = 16;

	// Data register of the UART, at the top of the address map
	localparam logic [ADDR_W-1:0] UART_ADDR = 18'h3_ff00;

	////////////////////////////////
	// Credits and request buffer
	////////////////////////////////

	// Outstanding requests, also the buffer depth
	localparam int REQ_CREDITS = 2;
	localparam int REQ_PTR_W = 1;
	// Holds 0 to REQ_CREDITS
	localparam int REQ_CNT_W = 2;

	typedef enum logic [0:0] {
		OP_LOAD  = 1'b0,
		OP_STORE = 1'b1
	} req_op_e;

	// One buffered request, 35 bits
	typedef struct packed {
		req_op_e op;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} mem_req_t;

endpackage

`default_nettype wire

//--- hw/uart_pkg.sv
`default_nettype none

package uart_pkg;

	// Receive queue
	localparam int RXQ_DEPTH = 16;
	localparam int RXQ_PTR_W = 4;
	localparam int RX_BYTE_W = 8;

	// Transmit gives up after this many cycles without tbre/tsre
	localparam int TX_WAIT_LIMIT = 64;
	localparam int TX_WAIT_W = 6;

	typedef enum logic [3:0] {
		IDLE,
		RX_STROBE,
		RX_CAPTURE,
		TX_DRIVE,
		TX_STROBE,
		TX_WAIT_TBRE,
		TX_WAIT_TSRE,
		POP
	} uart_state_e;

endpackage

`default_nettype wire

//--- hw/port_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface port_req_if;

	// Request side, held by the controller until done
	logic start;
	logic write;
	logic [mem_bus_pkg::ADDR_W-1:0] addr;
	logic [mem_bus_pkg::DATA_W-1:0] wdata;

	// Port status and result
	logic busy;
	logic drive;
	logic done;
	logic [mem_bus_pkg::DATA_W-1:0] rdata;
	logic err;

	modport ctrl (
		output start, write, addr, wdata,
		input busy, drive, done, rdata, err
	);

	modport port (
		input start, write, addr, wdata,
		output busy, drive, done, rdata, err
	);

endinterface

`default_nettype wire

//--- hw/sram_port.sv
`timescale 1ns/1ps
`default_nettype none

module sram_port (
	input wire clk,
	input wire rst,
	port_req_if.port ctl,
	input wire [mem_bus_pkg::DATA_W-1:0] bus_rdata,
	output logic ram_en,
	output logic ram_oe,
	output logic ram_we
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ENABLE,
		S_STROBE,
		S_DONE
	} sram_state_e;

	sram_state_e state;
	logic drive_q;
	logic [mem_bus_pkg::DATA_W-1:0] rdata_q;

	// One phase per clock, strobes are active low
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= S_IDLE;
			ram_en <= 1'b1;
			ram_oe <= 1'b1;
			ram_we <= 1'b1;
			drive_q <= 1'b0;
		end else begin
			case (state)
				S_IDLE: if (ctl.start) begin
					ram_en <= 1'b0;
					drive_q <= ctl.write;
					state <= S_ENABLE;
				end
				S_ENABLE: begin
					if (ctl.write)
						ram_we <= 1'b0;
					else
						ram_oe <= 1'b0;
					state <= S_STROBE;
				end
				// Rising we stores the word
				S_STROBE: begin
					ram_we <= 1'b1;
					state <= S_DONE;
				end
				default: begin
					ram_en <= 1'b1;
					ram_oe <= 1'b1;
					drive_q <= 1'b0;
					state <= S_IDLE;
				end
			endcase
		end
	end

	// Read data is stable one phase after oe falls
	always_ff @(posedge clk) begin
		if (state == S_STROBE && !ctl.write)
			rdata_q <= bus_rdata;
	end

	assign ctl.busy = (state != S_IDLE);
	assign ctl.done = (state == S_DONE);
	assign ctl.drive = drive_q;
	assign ctl.rdata = rdata_q;
	assign ctl.err = 1'b0;

endmodule

`default_nettype wire

//--- hw/uart_port.sv
`timescale 1ns/1ps
`default_nettype none

module uart_port (
	input wire clk,
	input wire rst,
	port_req_if.port ctl,
	input wire sram_busy,
	input wire [mem_bus_pkg::DATA_W-1:0] bus_rdata,
	input wire data_ready,
	input wire tbre,
	input wire tsre,
	output logic rdn,
	output logic wrn
);

	localparam int PAD_W = mem_bus_pkg::DATA_W - uart_pkg::RX_BYTE_W;

	uart_pkg::uart_state_e state;

	logic [uart_pkg::RX_BYTE_W-1:0] rxq [uart_pkg::RXQ_DEPTH];
	logic [uart_pkg::RXQ_PTR_W-1:0] rx_head;
	logic [uart_pkg::RXQ_PTR_W-1:0] rx_tail;
	logic [uart_pkg::RXQ_PTR_W:0] rx_count;
	logic rx_full;
	logic rx_empty;
	logic rx_push;
	logic rx_pop;

	logic [uart_pkg::TX_WAIT_W-1:0] wait_cnt;
	logic wait_over;
	logic tx_fail;
	logic tx_end;

	logic drive_q;
	logic done_q;
	logic [mem_bus_pkg::DATA_W-1:0] rdata_q;
	logic err_q;

	assign rx_full = (int'(rx_count) == uart_pkg::RXQ_DEPTH);
	assign rx_empty = (rx_count == '0);
	// Byte is lost when the queue is full
	assign rx_push = (state == uart_pkg::RX_CAPTURE) && !rx_full;
	assign rx_pop = (state == uart_pkg::POP) && !rx_empty;

	// One counter covers both the tbre and the tsre wait
	assign wait_over = (int'(wait_cnt) == uart_pkg::TX_WAIT_LIMIT - 1);
	assign tx_fail = wait_over &&
		((state == uart_pkg::TX_WAIT_TBRE && !tbre) ||
		(state == uart_pkg::TX_WAIT_TSRE && !tsre));
	assign tx_end = tx_fail || (state == uart_pkg::TX_WAIT_TSRE && tsre);

	//////////////////////////////
	// Port FSM
	//////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= uart_pkg::IDLE;
			rdn <= 1'b1;
			wrn <= 1'b1;
			drive_q <= 1'b0;
			done_q <= 1'b0;
			wait_cnt <= '0;
			rx_head <= '0;
			rx_tail <= '0;
			rx_count <= '0;
		end else begin
			done_q <= 1'b0;
			case (state)
				// A dispatched request wins over a pending receive
				uart_pkg::IDLE: if (ctl.start) begin
					drive_q <= ctl.write;
					state <= ctl.write ? uart_pkg::TX_DRIVE : uart_pkg::POP;
				end else if (data_ready && !sram_busy) begin
					rdn <= 1'b0;
					state <= uart_pkg::RX_STROBE;
				end
				uart_pkg::RX_STROBE: state <= uart_pkg::RX_CAPTURE;
				uart_pkg::RX_CAPTURE: begin
					rdn <= 1'b1;
					if (rx_push) begin
						rx_tail <= rx_tail + 1'b1;
						rx_count <= rx_count + 1'b1;
					end
					state <= uart_pkg::IDLE;
				end
				uart_pkg::TX_DRIVE: begin
					wrn <= 1'b0;
					state <= uart_pkg::TX_STROBE;
				end
				uart_pkg::TX_STROBE: begin
					wrn <= 1'b1;
					wait_cnt <= '0;
					state <= uart_pkg::TX_WAIT_TBRE;
				end
				uart_pkg::TX_WAIT_TBRE, uart_pkg::TX_WAIT_TSRE: if (tx_end) begin
					drive_q <= 1'b0;
					done_q <= 1'b1;
					state <= uart_pkg::IDLE;
				end else if (state == uart_pkg::TX_WAIT_TBRE && tbre) begin
					state <= uart_pkg::TX_WAIT_TSRE;
				end else begin
					wait_cnt <= wait_cnt + 1'b1;
				end
				uart_pkg::POP: begin
					if (rx_pop) begin
						rx_head <= rx_head + 1'b1;
						rx_count <= rx_count - 1'b1;
					end
					done_q <= 1'b1;
					state <= uart_pkg::IDLE;
				end
				default: state <= uart_pkg::IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Queue storage and result
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rx_push)
			rxq[rx_tail] <= bus_rdata[uart_pkg::RX_BYTE_W-1:0];
	end

	// Empty queue gives zero with err
	always_ff @(posedge clk) begin
		if (state == uart_pkg::POP) begin
			rdata_q <= rx_empty ? '0 : {{PAD_W{1'b0}}, rxq[rx_head]};
			err_q <= rx_empty;
		end else if (tx_end) begin
			rdata_q <= '0;
			err_q <= tx_fail;
		end
	end

	// Busy already in the cycle that decides on a capture
	assign ctl.busy = (state != uart_pkg::IDLE) || (data_ready && !sram_busy);
	assign ctl.drive = drive_q;
	assign ctl.done = done_q;
	assign ctl.rdata = rdata_q;
	assign ctl.err = err_q;

endmodule

`default_nettype wire

//--- hw/mem_access_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_ctrl (
	input wire clk,
	input wire rst,

	input wire req_valid,
	input wire req_write,
	input wire [mem_bus_pkg::ADDR_W-1:0] req_addr,
	input wire [mem_bus_pkg::DATA_W-1:0] req_wdata,
	output logic resp_valid,
	output logic [mem_bus_pkg::DATA_W-1:0] resp_rdata,
	output logic resp_err,

	output wire [mem_bus_pkg::ADDR_W-1:0] ram_addr,
	inout wire [mem_bus_pkg::DATA_W-1:0] ram_data,

	port_req_if.ctrl sram,
	port_req_if.ctrl uart,

	output wire [mem_bus_pkg::DATA_W-1:0] bus_rdata
);

	mem_bus_pkg::mem_req_t fifo_mem [mem_bus_pkg::REQ_CREDITS];
	logic [mem_bus_pkg::REQ_PTR_W-1:0] wr_ptr;
	logic [mem_bus_pkg::REQ_PTR_W-1:0] rd_ptr;
	logic [mem_bus_pkg::REQ_CNT_W-1:0] count;
	logic in_flight;

	mem_bus_pkg::mem_req_t head_req;
	logic head_is_uart;
	logic dispatch;
	logic port_done;
	logic bus_drive;

	function automatic logic [mem_bus_pkg::REQ_PTR_W-1:0] ptr_next(
		input logic [mem_bus_pkg::REQ_PTR_W-1:0] ptr
	);
		if (int'(ptr) == mem_bus_pkg::REQ_CREDITS - 1)
			return '0;
		return ptr + 1'b1;
	endfunction

	//////////////////////////////
	// Request buffer
	//////////////////////////////

	// Credits guarantee room, so every request is taken
	always_ff @(posedge clk) begin
		if (req_valid) begin
			fifo_mem[wr_ptr].op <= req_write ? mem_bus_pkg::OP_STORE : mem_bus_pkg::OP_LOAD;
			fifo_mem[wr_ptr].addr <= req_addr;
			fifo_mem[wr_ptr].wdata <= req_wdata;
		end
	end

	// Head leaves only when its port finishes
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			in_flight <= 1'b0;
		end else begin
			if (req_valid)
				wr_ptr <= ptr_next(wr_ptr);
			if (port_done)
				rd_ptr <= ptr_next(rd_ptr);
			case ({req_valid, port_done})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			if (dispatch)
				in_flight <= 1'b1;
			else if (port_done)
				in_flight <= 1'b0;
		end
	end

	//////////////////////////////
	// Decode and dispatch
	//////////////////////////////

	assign head_req = fifo_mem[rd_ptr];
	assign head_is_uart = (head_req.addr == mem_bus_pkg::UART_ADDR);

	// Held back while either port owns the bus, including a receive capture
	assign dispatch = (count != '0) && !in_flight && !sram.busy && !uart.busy;

	assign sram.start = dispatch && !head_is_uart;
	assign uart.start = dispatch && head_is_uart;

	assign sram.write = (head_req.op == mem_bus_pkg::OP_STORE);
	assign uart.write = (head_req.op == mem_bus_pkg::OP_STORE);
	assign sram.addr = head_req.addr;
	assign uart.addr = head_req.addr;
	assign sram.wdata = head_req.wdata;
	assign uart.wdata = head_req.wdata;

	//////////////////////////////
	// Shared data bus
	//////////////////////////////

	assign ram_addr = sram.addr;

	// Only the port holding busy raises drive
	assign bus_drive = sram.drive || uart.drive;
	assign ram_data = bus_drive ? head_req.wdata : 'z;
	assign bus_rdata = ram_data;

	// Response, one cycle after done
	assign port_done = in_flight && (sram.done || uart.done);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			resp_valid <= 1'b0;
		else
			resp_valid <= port_done;
	end

	always_ff @(posedge clk) begin
		if (port_done) begin
			resp_rdata <= sram.done ? sram.rdata : uart.rdata;
			resp_err <= sram.done ? sram.err : uart.err;
		end
	end

endmodule

`default_nettype wire

//--- hw/mem_uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_uart_top (
	input wire clk,
	input wire rst,

	// Processor side
	input wire req_valid,
	input wire req_write,
	input wire [mem_bus_pkg::ADDR_W-1:0] req_addr,
	input wire [mem_bus_pkg::DATA_W-1:0] req_wdata,
	output wire resp_valid,
	output wire [mem_bus_pkg::DATA_W-1:0] resp_rdata,
	output wire resp_err,

	// SRAM chip
	output wire [mem_bus_pkg::ADDR_W-1:0] ram_addr,
	inout wire [mem_bus_pkg::DATA_W-1:0] ram_data,
	output wire ram_en,
	output wire ram_oe,
	output wire ram_we,

	// UART chip, shares ram_data
	input wire data_ready,
	input wire tbre,
	input wire tsre,
	output wire rdn,
	output wire wrn
);

	wire [mem_bus_pkg::DATA_W-1:0] bus_rdata;

	port_req_if sram_if ();
	port_req_if uart_if ();

	mem_access_ctrl u_ctrl (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_write(req_write),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.resp_valid(resp_valid),
		.resp_rdata(resp_rdata),
		.resp_err(resp_err),
		.ram_addr(ram_addr),
		.ram_data(ram_data),
		.sram(sram_if.ctrl),
		.uart(uart_if.ctrl),
		.bus_rdata(bus_rdata)
	);

	sram_port u_sram (
		.clk(clk),
		.rst(rst),
		.ctl(sram_if.port),
		.bus_rdata(bus_rdata),
		.ram_en(ram_en),
		.ram_oe(ram_oe),
		.ram_we(ram_we)
	);

	uart_port u_uart (
		.clk(clk),
		.rst(rst),
		.ctl(uart_if.port),
		.sram_busy(sram_if.busy),
		.bus_rdata(bus_rdata),
		.data_ready(data_ready),
		.tbre(tbre),
		.tsre(tsre),
		.rdn(rdn),
		.wrn(wrn)
	);

endmodule

`default_nettype wire

//--- sim/mem_uart_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mem_uart_checker (
	input wire clk,
	input wire rst,
	input wire req_valid,
	input wire req_write,
	input wire [mem_bus_pkg::ADDR_W-1:0] req_addr,
	input wire [mem_bus_pkg::DATA_W-1:0] req_wdata,
	input wire resp_valid,
	input wire [mem_bus_pkg::DATA_W-1:0] resp_rdata,
	input wire resp_err,
	input wire [mem_bus_pkg::DATA_W-1:0] ram_data,
	input wire ram_en,
	input wire ram_oe,
	input wire ram_we,
	input wire rdn,
	input wire wrn,
	input wire tbre_hold,
	output int error_count,
	output int req_count,
	output int resp_count
);

	// Requests not yet answered, oldest first
	mem_bus_pkg::mem_req_t pending [$];
	mem_bus_pkg::mem_req_t new_req;
	logic [mem_bus_pkg::DATA_W-1:0] mem_model [1 << mem_bus_pkg::ADDR_W];
	logic [7:0] rx_model [$];
	logic [7:0] rx_byte_q;
	logic rdn_q;
	logic tx_fail_exp;
	logic seen_req;

	function automatic logic [15:0] fill_word(input logic [17:0] a);
		return a[15:0] ^ {a[17:16], 6'h2b, a[17:16], 6'h1d};
	endfunction

	task automatic check_value(input string name, input logic [15:0] exp,
		input logic [15:0] act);
		if (act !== exp) begin
			$display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
			error_count++;
		end
	endtask

	task automatic check_response();
		mem_bus_pkg::mem_req_t req;
		logic [15:0] exp_rdata;
		if (pending.size() == 0) begin
			$display("A response arrived at %0t with no request outstanding", $time);
			error_count++;
			return;
		end
		req = pending.pop_front();
		resp_count++;
		if (req.addr == mem_bus_pkg::UART_ADDR) begin
			if (req.op == mem_bus_pkg::OP_STORE) begin
				check_value("resp_err", 16'(tx_fail_exp), 16'(resp_err));
			end else if (rx_model.size() == 0) begin
				// Empty queue reads as zero with err
				check_value("resp_rdata", 16'h0000, resp_rdata);
				check_value("resp_err", 16'd1, 16'(resp_err));
			end else begin
				exp_rdata = {8'h00, rx_model.pop_front()};
				check_value("resp_rdata", exp_rdata, resp_rdata);
				check_value("resp_err", 16'd0, 16'(resp_err));
			end
		end else if (req.op == mem_bus_pkg::OP_STORE) begin
			mem_model[req.addr] = req.wdata;
			check_value("resp_err", 16'd0, 16'(resp_err));
		end else begin
			check_value("resp_rdata", mem_model[req.addr], resp_rdata);
			check_value("resp_err", 16'd0, 16'(resp_err));
		end
	endtask

	initial begin
		error_count = 0;
		req_count = 0;
		resp_count = 0;
		rdn_q = 1'b1;
		rx_byte_q = '0;
		tx_fail_exp = 1'b0;
		seen_req = 1'b0;
		for (int i = 0; i < (1 << mem_bus_pkg::ADDR_W); i++)
			mem_model[i] = fill_word(18'(i));
	end

	//////////////////////////////
	// Sampled mid-cycle
	//////////////////////////////

	always @(negedge clk) begin
		// Receive byte is on the bus while rdn is low
		if (rdn === 1'b0) begin
			rx_byte_q = ram_data[7:0];
		end else if (rdn_q === 1'b0) begin
			// Full queue drops the byte
			if (rx_model.size() < uart_pkg::RXQ_DEPTH)
				rx_model.push_back(rx_byte_q);
		end
		rdn_q = rdn;

		if (wrn === 1'b0) begin
			if (pending.size() == 0 || pending[0].addr != mem_bus_pkg::UART_ADDR ||
				pending[0].op != mem_bus_pkg::OP_STORE) begin
				$display("A wrn strobe at %0t came without a UART store in flight", $time);
				error_count++;
			end else begin
				check_value("ram_data", pending[0].wdata, ram_data);
			end
			tx_fail_exp = tbre_hold;
		end

		// Quiet pins from reset up to the first request
		if (!seen_req) begin
			check_value("ram_en", 16'd1, 16'(ram_en));
			check_value("ram_oe", 16'd1, 16'(ram_oe));
			check_value("ram_we", 16'd1, 16'(ram_we));
			check_value("rdn", 16'd1, 16'(rdn));
			check_value("wrn", 16'd1, 16'(wrn));
			check_value("resp_valid", 16'd0, 16'(resp_valid));
		end

		if (resp_valid === 1'b1)
			check_response();

		if (rst === 1'b1 && req_valid === 1'b1) begin
			new_req.op = req_write ? mem_bus_pkg::OP_STORE : mem_bus_pkg::OP_LOAD;
			new_req.addr = req_addr;
			new_req.wdata = req_wdata;
			pending.push_back(new_req);
			req_count++;
			seen_req = 1'b1;
			if (pending.size() > mem_bus_pkg::REQ_CREDITS) begin
				$display("More than %0d requests outstanding at %0t",
					mem_bus_pkg::REQ_CREDITS, $time);
				error_count++;
			end
		end
	end

endmodule

`default_nettype wire

//--- sim/tb_mem_uart.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_uart;

	logic clk;
	logic rst;
	logic req_valid;
	logic req_write;
	logic [mem_bus_pkg::ADDR_W-1:0] req_addr;
	logic [mem_bus_pkg::DATA_W-1:0] req_wdata;
	wire resp_valid;
	wire [mem_bus_pkg::DATA_W-1:0] resp_rdata;
	wire resp_err;
	wire [mem_bus_pkg::ADDR_W-1:0] ram_addr;
	wire [mem_bus_pkg::DATA_W-1:0] ram_data;
	wire ram_en;
	wire ram_oe;
	wire ram_we;
	wire rdn;
	wire wrn;
	logic data_ready;
	logic tbre;
	logic tsre;

	logic [mem_bus_pkg::DATA_W-1:0] sram_mem [1 << mem_bus_pkg::ADDR_W];
	logic [7:0] rx_byte;
	logic tbre_hold;
	int rx_rate;
	int credits;
	int issued;
	int tb_errors;
	int seed;
	int chk_errors;
	int chk_reqs;
	int chk_resps;

	function automatic logic [15:0] fill_word(input logic [17:0] a);
		return a[15:0] ^ {a[17:16], 6'h2b, a[17:16], 6'h1d};
	endfunction

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	mem_uart_top dut0 (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_write(req_write),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.resp_valid(resp_valid),
		.resp_rdata(resp_rdata),
		.resp_err(resp_err),
		.ram_addr(ram_addr),
		.ram_data(ram_data),
		.ram_en(ram_en),
		.ram_oe(ram_oe),
		.ram_we(ram_we),
		.data_ready(data_ready),
		.tbre(tbre),
		.tsre(tsre),
		.rdn(rdn),
		.wrn(wrn)
	);

	mem_uart_checker chk (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_write(req_write),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.resp_valid(resp_valid),
		.resp_rdata(resp_rdata),
		.resp_err(resp_err),
		.ram_data(ram_data),
		.ram_en(ram_en),
		.ram_oe(ram_oe),
		.ram_we(ram_we),
		.rdn(rdn),
		.wrn(wrn),
		.tbre_hold(tbre_hold),
		.error_count(chk_errors),
		.req_count(chk_reqs),
		.resp_count(chk_resps)
	);

	//////////////////////////////
	// SRAM and UART chip models
	//////////////////////////////

	initial begin
		for (int i = 0; i < (1 << mem_bus_pkg::ADDR_W); i++)
			sram_mem[i] = fill_word(18'(i));
	end

	assign ram_data = (ram_en == 1'b0 && ram_oe == 1'b0) ? sram_mem[ram_addr] : 'z;
	// Upper byte is noise the port must strip
	assign ram_data = (rdn == 1'b0) ? {~rx_byte, rx_byte} : 'z;

	// Store lands on the rising edge of we
	always @(posedge ram_we) begin
		if (rst === 1'b1 && ram_en === 1'b0)
			sram_mem[ram_addr] = ram_data;
	end

	task automatic rx_chip();
		forever begin
			@(posedge clk);
			#1;
			if (rdn == 1'b0) begin
				data_ready = 1'b0;
			end else if (!data_ready && $urandom_range(99) < rx_rate) begin
				rx_byte = 8'($urandom);
				data_ready = 1'b1;
			end
		end
	endtask

	// tbre then tsre after random delays, tbre withheld in hold mode
	task automatic tx_chip();
		int tbre_dly;
		int tsre_dly;
		tbre_dly = 0;
		tsre_dly = 0;
		forever begin
			@(posedge clk);
			#1;
			if (wrn == 1'b0) begin
				tbre = 1'b0;
				tsre = 1'b0;
				tbre_dly = $urandom_range(8, 1);
				tsre_dly = $urandom_range(8, 1);
			end else if (!tbre) begin
				if (tbre_hold)
					tbre = 1'b0;
				else if (tbre_dly > 0)
					tbre_dly--;
				else
					tbre = 1'b1;
			end else if (!tsre) begin
				if (tsre_dly > 0)
					tsre_dly--;
				else
					tsre = 1'b1;
			end
		end
	endtask

	//////////////////////////////
	// Requester
	//////////////////////////////

	task automatic finish_run();
		$display("Errors: %0d in checker, %0d in testbench", chk_errors, tb_errors);
		if (chk_errors + tb_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	endtask

	task automatic timeout(input string what);
		$display("Timeout while waiting for %s", what);
		tb_errors++;
		finish_run();
	endtask

	// Each response pulse hands back a credit
	task automatic next_cycle();
		@(posedge clk);
		#1;
		if (resp_valid === 1'b1)
			credits++;
	endtask

	task automatic send_req(input logic w, input logic [17:0] a, input logic [15:0] d);
		int waited;
		waited = 0;
		while (credits == 0 && waited < 300) begin
			next_cycle();
			waited++;
		end
		if (credits == 0) begin
			timeout("a free request credit");
		end else begin
			req_valid = 1'b1;
			req_write = w;
			req_addr = a;
			req_wdata = d;
			credits--;
			issued++;
			next_cycle();
			req_valid = 1'b0;
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (credits != mem_bus_pkg::REQ_CREDITS && waited < 1000) begin
			next_cycle();
			waited++;
		end
		if (credits != mem_bus_pkg::REQ_CREDITS)
			timeout("all outstanding responses");
		else
			next_cycle();
	endtask

	// Small pool, the UART register, or anywhere
	task automatic random_req();
		logic [17:0] a;
		int pick;
		pick = $urandom_range(9);
		if (pick < 5)
			a = 18'h0_0100 + 18'(4 * $urandom_range(7));
		else if (pick < 8)
			a = mem_bus_pkg::UART_ADDR;
		else
			a = 18'($urandom);
		send_req(1'($urandom_range(1)), a, 16'($urandom));
	endtask

	initial begin
		seed = $urandom(87782);
		rst = 1'b0;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		data_ready = 1'b0;
		tbre = 1'b1;
		tsre = 1'b1;
		rx_byte = '0;
		rx_rate = 0;
		tbre_hold = 1'b0;
		credits = mem_bus_pkg::REQ_CREDITS;
		issued = 0;
		tb_errors = 0;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b1;
		fork
			rx_chip();
			tx_chip();
		join_none
		repeat (10) next_cycle();

		// Mixed traffic with occasional receive bytes
		rx_rate = 8;
		repeat (300) begin
			random_req();
			if ($urandom_range(3) == 0)
				next_cycle();
		end
		drain();

		// Transmit that never sees tbre
		tbre_hold = 1'b1;
		send_req(1'b1, mem_bus_pkg::UART_ADDR, 16'h5a3c);
		send_req(1'b0, 18'h0_0104, '0);
		send_req(1'b1, mem_bus_pkg::UART_ADDR, 16'hc3e1);
		send_req(1'b1, 18'h0_0104, 16'h1234);
		send_req(1'b0, 18'h0_0104, '0);
		drain();
		tbre_hold = 1'b0;

		// Overfill the receive queue, then empty it past the end
		rx_rate = 60;
		repeat (200) next_cycle();
		rx_rate = 0;
		repeat (uart_pkg::RXQ_DEPTH + 4)
			send_req(1'b0, mem_bus_pkg::UART_ADDR, '0);
		drain();

		if (chk_reqs != issued || chk_resps != issued) begin
			$display("Counts differ: %0d issued, %0d seen, %0d answered",
				issued, chk_reqs, chk_resps);
			tb_errors++;
		end
		finish_run();
	end

endmodule

`default_nettype wire

//--- filelist.f
hw/mem_bus_pkg.sv
hw/uart_pkg.sv
hw/port_req_if.sv
hw/sram_port.sv
hw/uart_port.sv
hw/mem_access_ctrl.sv
hw/mem_uart_top.sv
sim/mem_uart_checker.sv
sim/tb_mem_uart.sv

//--- Bender.yml
package:
  name: mem_uart

sources:
  - target: rtl
    files:
      - hw/mem_bus_pkg.sv
      - hw/uart_pkg.sv
      - hw/port_req_if.sv
      - hw/sram_port.sv
      - hw/uart_port.sv
      - hw/mem_access_ctrl.sv
      - hw/mem_uart_top.sv

  - target: simulation
    files:
      - sim/mem_uart_checker.sv
      - sim/tb_mem_uart.sv
